// ==== src/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	//////////////////////////////////////////////////
	// Opcode and function fields
	localparam logic [5:0] OP_RTYPE = 6'h00; // add, sub, and, or, slt
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	//////////////////////////////////////////////////
	// Instruction word, two views of the same bits
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt; // Ignored by this core
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt; // Destination for addi and lw
		logic [15:0] imm16;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

	//////////////////////////////////////////////////
	// Datapath select codes
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REG = 2'd0, // Value read in decode
		FWD_MEM = 2'd1, // From EX/MEM
		FWD_WB  = 2'd2  // From MEM/WB
	} fwd_sel_e;

endpackage

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
	parameter int PC_BITS = 7
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic               stall,
	input  logic               branch_taken,
	input  logic [PC_BITS-1:0] branch_target,
	input  logic               imem_we,
	input  logic [PC_BITS-1:0] imem_addr,
	input  logic [31:0]        imem_data,
	output logic               if_valid,
	output logic [PC_BITS-1:0] if_pc_next,
	output mips_pkg::instr_t   if_instr
);

	logic [31:0] imem [0:(1 << PC_BITS) - 1]; // Word addressed program store
	logic [PC_BITS-1:0] pc;
	logic [PC_BITS-1:0] pc_plus1;
	logic advance;

	assign pc_plus1 = pc + 1'b1;
	assign advance = enable && !branch_taken && !stall; // Normal fetch step

	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_data; // Load port, used while halted
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			if_valid <= 1'b0;
		end else if (enable) begin
			if (branch_taken) begin
				pc <= branch_target; // Redirect
				if_valid <= 1'b0; // Squash younger fetch
			end else if (!stall) begin
				pc <= pc_plus1;
				if_valid <= 1'b1;
			end
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (advance) begin
			if_instr <= imem[pc];
			if_pc_next <= pc_plus1;
		end
	end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
	parameter int PC_BITS = 7
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic               stall,
	input  logic               branch_taken,
	input  logic               if_valid,
	input  mips_pkg::instr_t   if_instr,
	input  logic [PC_BITS-1:0] if_pc_next,
	input  logic               wb_valid,
	input  logic [4:0]         wb_dst,
	input  logic [31:0]        wb_data,
	output logic               id_valid,
	output mips_pkg::alu_op_e  id_alu_op,
	output logic               id_alu_src,
	output logic               id_mem_read,
	output logic               id_mem_write,
	output logic               id_reg_write,
	output logic               id_branch,
	output logic [31:0]        id_data_a,
	output logic [31:0]        id_data_b,
	output logic [31:0]        id_imm,
	output logic [4:0]         id_rs,
	output logic [4:0]         id_rt,
	output logic [4:0]         id_dst,
	output logic [PC_BITS-1:0] id_pc_next
);

	import mips_pkg::*;

	logic [31:0] rf [0:31];
	alu_op_e dec_alu_op;
	logic dec_alu_src;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_reg_write;
	logic dec_branch;
	logic [4:0] dec_dst;
	logic [31:0] rd_a;
	logic [31:0] rd_b;
	logic [31:0] imm_ext;

	//////////////////////////////////////////////////
	// Control decode
	always_comb begin
		dec_alu_op = ALU_ADD;
		dec_alu_src = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_reg_write = 1'b0;
		dec_branch = 1'b0;
		dec_dst = if_instr.i.rt; // I-type writes rt
		case (if_instr.r.opcode)
			OP_RTYPE: begin
				dec_dst = if_instr.r.rd;
				dec_reg_write = 1'b1;
				case (if_instr.r.funct)
					FN_ADD: dec_alu_op = ALU_ADD;
					FN_SUB: dec_alu_op = ALU_SUB;
					FN_AND: dec_alu_op = ALU_AND;
					FN_OR: dec_alu_op = ALU_OR;
					FN_SLT: dec_alu_op = ALU_SLT;
					default: dec_reg_write = 1'b0; // Unknown funct, e.g. nop
				endcase
			end
			OP_ADDI: begin
				dec_alu_src = 1'b1;
				dec_reg_write = 1'b1;
			end
			OP_LW: begin
				dec_alu_src = 1'b1;
				dec_mem_read = 1'b1;
				dec_reg_write = 1'b1;
			end
			OP_SW: begin
				dec_alu_src = 1'b1;
				dec_mem_write = 1'b1;
			end
			OP_BEQ: begin
				dec_branch = 1'b1;
				dec_alu_op = ALU_SUB;
			end
			default: begin
				dec_reg_write = 1'b0; // Unsupported opcode runs as nop
			end
		endcase
	end

	assign imm_ext = {{16{if_instr.i.imm16[15]}}, if_instr.i.imm16};

	//////////////////////////////////////////////////
	// Register file, write-through on read
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_valid) begin
			rf[wb_dst] <= wb_data; // wb_valid never set for r0
		end
	end

	assign rd_a = (wb_valid && wb_dst == if_instr.r.rs) ? wb_data : rf[if_instr.r.rs];
	assign rd_b = (wb_valid && wb_dst == if_instr.r.rt) ? wb_data : rf[if_instr.r.rt];

	//////////////////////////////////////////////////
	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_reg_write <= 1'b0;
			id_branch <= 1'b0;
		end else if (enable) begin
			if (stall || branch_taken) begin
				id_valid <= 1'b0; // Bubble
				id_mem_read <= 1'b0;
				id_mem_write <= 1'b0;
				id_reg_write <= 1'b0;
				id_branch <= 1'b0;
			end else begin
				id_valid <= if_valid;
				id_mem_read <= if_valid & dec_mem_read;
				id_mem_write <= if_valid & dec_mem_write;
				id_reg_write <= if_valid & dec_reg_write;
				id_branch <= if_valid & dec_branch;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			id_alu_op <= dec_alu_op;
			id_alu_src <= dec_alu_src;
			id_data_a <= rd_a;
			id_data_b <= rd_b;
			id_imm <= imm_ext;
			id_rs <= if_instr.r.rs;
			id_rt <= if_instr.r.rt;
			id_dst <= dec_dst;
			id_pc_next <= if_pc_next;
		end
	end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage #(
	parameter int PC_BITS = 7
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic               id_valid,
	input  mips_pkg::alu_op_e  id_alu_op,
	input  logic               id_alu_src,
	input  logic               id_mem_read,
	input  logic               id_mem_write,
	input  logic               id_reg_write,
	input  logic               id_branch,
	input  logic [31:0]        id_data_a,
	input  logic [31:0]        id_data_b,
	input  logic [31:0]        id_imm,
	input  logic [4:0]         id_dst,
	input  logic [PC_BITS-1:0] id_pc_next,
	input  mips_pkg::fwd_sel_e fwd_a,
	input  mips_pkg::fwd_sel_e fwd_b,
	input  logic [31:0]        mem_fwd_data,
	input  logic [31:0]        wb_fwd_data,
	output logic               branch_taken,
	output logic [PC_BITS-1:0] branch_target,
	output logic               ex_valid,
	output logic [31:0]        ex_result,
	output logic [31:0]        ex_store_data,
	output logic [4:0]         ex_dst,
	output logic               ex_mem_read,
	output logic               ex_mem_write,
	output logic               ex_reg_write
);

	import mips_pkg::*;

	logic [31:0] op_a;
	logic [31:0] op_b; // Also the store data
	logic [31:0] alu_b;
	logic [31:0] alu_y;

	function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] reg_val,
		input logic [31:0] mem_val, input logic [31:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = fwd_mux(fwd_a, id_data_a, mem_fwd_data, wb_fwd_data);
	assign op_b = fwd_mux(fwd_b, id_data_b, mem_fwd_data, wb_fwd_data);
	assign alu_b = id_alu_src ? id_imm : op_b;

	always_comb begin
		case (id_alu_op)
			ALU_SUB: alu_y = op_a - alu_b;
			ALU_AND: alu_y = op_a & alu_b;
			ALU_OR: alu_y = op_a | alu_b;
			ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
			default: alu_y = op_a + alu_b; // add, addi, address calc
		endcase
	end

	// beq resolves here, offset in words from pc+1
	assign branch_taken = id_valid && id_branch && (op_a == op_b);
	assign branch_target = id_pc_next + id_imm[PC_BITS-1:0];

	//////////////////////////////////////////////////
	// EX/MEM register
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_reg_write <= 1'b0;
		end else if (enable) begin
			ex_valid <= id_valid;
			ex_mem_read <= id_mem_read;
			ex_mem_write <= id_mem_write;
			ex_reg_write <= id_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			ex_result <= alu_y;
			ex_store_data <= op_b;
			ex_dst <= id_dst;
		end
	end

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_stage #(
	parameter int PC_BITS = 7
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic               ex_valid,
	input  logic [31:0]        ex_result,
	input  logic [31:0]        ex_store_data,
	input  logic [4:0]         ex_dst,
	input  logic               ex_mem_read,
	input  logic               ex_mem_write,
	input  logic               ex_reg_write,
	output logic [31:0]        mem_fwd_data,
	output logic               wb_valid,
	output logic [4:0]         wb_dst,
	output logic [31:0]        wb_data,
	output logic               store_valid,
	output logic [PC_BITS-1:0] store_addr,
	output logic [31:0]        store_data
);

	logic [31:0] dmem [0:(1 << PC_BITS) - 1];
	logic [PC_BITS-1:0] addr;
	logic wb_valid_q;

	assign addr = ex_result[PC_BITS-1:0]; // Word address
	assign mem_fwd_data = ex_result; // Loads never forward from here

	assign store_valid = enable && ex_valid && ex_mem_write;
	assign store_addr = addr;
	assign store_data = ex_store_data;

	always_ff @(posedge clk) begin
		if (store_valid) begin
			dmem[addr] <= store_data;
		end
	end

	//////////////////////////////////////////////////
	// MEM/WB register
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid_q <= 1'b0;
		end else if (enable) begin
			wb_valid_q <= ex_valid && ex_reg_write && (ex_dst != 5'd0); // r0 writes dropped
		end
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			wb_dst <= ex_dst;
			wb_data <= ex_mem_read ? dmem[addr] : ex_result;
		end
	end

	assign wb_valid = wb_valid_q && enable; // One retire per advance

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input  logic [4:0]         id_rs,
	input  logic [4:0]         id_rt,
	input  logic               id_valid,
	input  logic               id_mem_read,
	input  logic [4:0]         id_dst,
	input  logic [4:0]         ex_dst,
	input  logic               ex_reg_write,
	input  logic               ex_valid,
	input  logic [4:0]         wb_dst,
	input  logic               wb_valid,
	input  mips_pkg::instr_t   if_instr,
	input  logic               if_valid,
	output mips_pkg::fwd_sel_e fwd_a,
	output mips_pkg::fwd_sel_e fwd_b,
	output logic               stall
);

	import mips_pkg::*;

	logic mem_writes;
	logic load_in_ex;

	function automatic fwd_sel_e pick_src(input logic [4:0] src);
		if (mem_writes && ex_dst == src) begin
			return FWD_MEM; // Newest value wins
		end
		if (wb_valid && wb_dst == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign mem_writes = ex_valid && ex_reg_write && (ex_dst != 5'd0);

	assign fwd_a = id_valid ? pick_src(id_rs) : FWD_REG;
	assign fwd_b = id_valid ? pick_src(id_rt) : FWD_REG;

	// Load in execute feeding the instruction in decode
	assign load_in_ex = id_valid && id_mem_read && (id_dst != 5'd0);
	assign stall = load_in_ex && if_valid &&
		(id_dst == if_instr.r.rs || id_dst == if_instr.r.rt);

endmodule

`default_nettype wire

// ==== src/pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline #(
	parameter int PC_BITS = 7
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic               imem_we,
	input  logic [PC_BITS-1:0] imem_addr,
	input  logic [31:0]        imem_data,
	output logic               retire_valid,
	output logic [4:0]         retire_dst,
	output logic [31:0]        retire_data,
	output logic               store_valid,
	output logic [PC_BITS-1:0] store_addr,
	output logic [31:0]        store_data
);

	import mips_pkg::*;

	//////////////////////////////////////////////////
	// Stage wires
	logic if_valid;
	logic [PC_BITS-1:0] if_pc_next;
	instr_t if_instr;

	logic id_valid;
	alu_op_e id_alu_op;
	logic id_alu_src;
	logic id_mem_read;
	logic id_mem_write;
	logic id_reg_write;
	logic id_branch;
	logic [31:0] id_data_a;
	logic [31:0] id_data_b;
	logic [31:0] id_imm;
	logic [4:0] id_rs;
	logic [4:0] id_rt;
	logic [4:0] id_dst;
	logic [PC_BITS-1:0] id_pc_next;

	logic ex_valid;
	logic [31:0] ex_result;
	logic [31:0] ex_store_data;
	logic [4:0] ex_dst;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_reg_write;
	logic [31:0] mem_fwd_data;

	logic stall;
	logic branch_taken;
	logic [PC_BITS-1:0] branch_target;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;

	//////////////////////////////////////////////////
	// Stages
	fetch_stage #(.PC_BITS(PC_BITS)) u_fetch (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.stall(stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.if_valid(if_valid),
		.if_pc_next(if_pc_next),
		.if_instr(if_instr)
	);

	decode_stage #(.PC_BITS(PC_BITS)) u_decode (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.stall(stall),
		.branch_taken(branch_taken),
		.if_valid(if_valid),
		.if_instr(if_instr),
		.if_pc_next(if_pc_next),
		.wb_valid(retire_valid), // Write-back port is the retire stream
		.wb_dst(retire_dst),
		.wb_data(retire_data),
		.id_valid(id_valid),
		.id_alu_op(id_alu_op),
		.id_alu_src(id_alu_src),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_reg_write(id_reg_write),
		.id_branch(id_branch),
		.id_data_a(id_data_a),
		.id_data_b(id_data_b),
		.id_imm(id_imm),
		.id_rs(id_rs),
		.id_rt(id_rt),
		.id_dst(id_dst),
		.id_pc_next(id_pc_next)
	);

	execute_stage #(.PC_BITS(PC_BITS)) u_execute (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.id_valid(id_valid),
		.id_alu_op(id_alu_op),
		.id_alu_src(id_alu_src),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_reg_write(id_reg_write),
		.id_branch(id_branch),
		.id_data_a(id_data_a),
		.id_data_b(id_data_b),
		.id_imm(id_imm),
		.id_dst(id_dst),
		.id_pc_next(id_pc_next),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.mem_fwd_data(mem_fwd_data),
		.wb_fwd_data(retire_data),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.ex_valid(ex_valid),
		.ex_result(ex_result),
		.ex_store_data(ex_store_data),
		.ex_dst(ex_dst),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_reg_write(ex_reg_write)
	);

	mem_stage #(.PC_BITS(PC_BITS)) u_mem (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.ex_valid(ex_valid),
		.ex_result(ex_result),
		.ex_store_data(ex_store_data),
		.ex_dst(ex_dst),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_reg_write(ex_reg_write),
		.mem_fwd_data(mem_fwd_data),
		.wb_valid(retire_valid),
		.wb_dst(retire_dst),
		.wb_data(retire_data),
		.store_valid(store_valid),
		.store_addr(store_addr),
		.store_data(store_data)
	);

	//////////////////////////////////////////////////
	// Forwarding and load-use stall
	hazard_unit u_hazard (
		.id_rs(id_rs),
		.id_rt(id_rt),
		.id_valid(id_valid),
		.id_mem_read(id_mem_read),
		.id_dst(id_dst),
		.ex_dst(ex_dst),
		.ex_reg_write(ex_reg_write),
		.ex_valid(ex_valid),
		.wb_dst(retire_dst),
		.wb_valid(retire_valid),
		.if_instr(if_instr),
		.if_valid(if_valid),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall(stall)
	);

endmodule

`default_nettype wire

// ==== sim/pipeline_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline_checker #(
	parameter int PC_BITS = 7
) (
	input  logic               clk,
	input  logic               imem_we,
	input  logic [PC_BITS-1:0] imem_addr,
	input  logic [31:0]        imem_data,
	input  logic               retire_valid,
	input  logic [4:0]         retire_dst,
	input  logic [31:0]        retire_data,
	input  logic               store_valid,
	input  logic [PC_BITS-1:0] store_addr,
	input  logic [31:0]        store_data,
	input  logic               start,
	input  logic               finish_test,
	input  logic               report,
	input  logic [2:0]         test_id,
	input  logic [7:0]         prog_len,
	output logic               done,
	output int                 errors
);

	import mips_pkg::*;

	logic [31:0] imem_copy [0:(1 << PC_BITS) - 1]; // Snooped from the load port
	logic [31:0] mregs [0:31]; // Model register file
	logic [31:0] mdmem [0:(1 << PC_BITS) - 1]; // Model data memory, kept across tests
	logic [36:0] exp_ret [$]; // {dst, data}
	logic [PC_BITS+31:0] exp_st [$]; // {addr, data}
	int test_errs = 0;
	int n_ret = 0;
	int n_st = 0;
	int tests_run = 0;
	int tests_failed = 0;

	initial begin
		errors = 0;
		done = 1'b0;
	end

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "reset_idle";
			3'd2: return "alu_chain";
			3'd3: return "mem_pairs";
			3'd4: return "branches";
			3'd5: return "enable_gaps";
			default: return "reg_zero";
		endcase
	endfunction

	task automatic write_reg(input logic [4:0] dst, input logic [31:0] val);
		if (dst != 5'd0) begin
			mregs[dst] = val;
			exp_ret.push_back({dst, val}); // Only nonzero writes retire
		end
	endtask

	//////////////////////////////////////////////////
	// Instruction-set model of the loaded program
	task automatic run_model();
		int pc;
		int steps;
		instr_t w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] sum;
		logic [PC_BITS-1:0] tgt;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		exp_ret.delete();
		exp_st.delete();
		pc = 0;
		steps = 0;
		while (pc < int'(prog_len) && steps < 256) begin
			w = imem_copy[pc];
			steps++;
			a = mregs[w.r.rs];
			b = mregs[w.r.rt];
			imm = {{16{w.i.imm16[15]}}, w.i.imm16};
			sum = a + imm;
			pc = pc + 1;
			case (w.r.opcode)
				OP_RTYPE: begin
					case (w.r.funct)
						FN_ADD: write_reg(w.r.rd, a + b);
						FN_SUB: write_reg(w.r.rd, a - b);
						FN_AND: write_reg(w.r.rd, a & b);
						FN_OR: write_reg(w.r.rd, a | b);
						FN_SLT: write_reg(w.r.rd, {31'd0, $signed(a) < $signed(b)});
						default: ; // nop
					endcase
				end
				OP_ADDI: write_reg(w.i.rt, sum);
				OP_LW: write_reg(w.i.rt, mdmem[sum[PC_BITS-1:0]]);
				OP_SW: begin
					mdmem[sum[PC_BITS-1:0]] = b;
					exp_st.push_back({sum[PC_BITS-1:0], b});
				end
				OP_BEQ: begin
					if (a == b) begin
						tgt = PC_BITS'(pc) + imm[PC_BITS-1:0]; // Word offset from pc+1
						pc = int'(tgt);
					end
				end
				default: ;
			endcase
		end
	endtask

	always @(posedge clk) begin
		if (imem_we) begin
			imem_copy[imem_addr] = imem_data;
		end
		if (start) begin
			run_model();
			test_errs = 0;
			n_ret = 0;
			n_st = 0;
		end
		if (retire_valid) begin
			if (exp_ret.size() == 0) begin
				$display("Error in %s: retire to r%0d with no instruction left to retire",
					test_name(test_id), retire_dst);
				test_errs++;
			end else begin
				if (exp_ret[0] !== {retire_dst, retire_data}) begin
					$display("Fail %s retire: expected r%0d=%h, actual r%0d=%h",
						test_name(test_id), exp_ret[0][36:32], exp_ret[0][31:0],
						retire_dst, retire_data);
					test_errs++;
				end
				void'(exp_ret.pop_front());
				n_ret++;
			end
		end
		if (store_valid) begin
			if (exp_st.size() == 0) begin
				$display("Error in %s: store to word %0d that the program never makes",
					test_name(test_id), store_addr);
				test_errs++;
			end else begin
				if (exp_st[0] !== {store_addr, store_data}) begin
					$display("Fail %s store: expected [%0d]=%h, actual [%0d]=%h",
						test_name(test_id), exp_st[0][PC_BITS+31:32], exp_st[0][31:0],
						store_addr, store_data);
					test_errs++;
				end
				void'(exp_st.pop_front());
				n_st++;
			end
		end
		if (finish_test) begin
			if (exp_ret.size() != 0 || exp_st.size() != 0) begin
				$display("Error in %s: %0d retires and %0d stores never appeared",
					test_name(test_id), exp_ret.size(), exp_st.size());
				test_errs++;
			end
			tests_run++;
			if (test_errs != 0) begin
				tests_failed++;
			end
			errors += test_errs;
			$display("test %0d %-12s %s (%0d retires, %0d stores)", test_id,
				test_name(test_id), (test_errs == 0) ? "ok" : "FAILED", n_ret, n_st);
		end
		if (report) begin
			$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
				tests_run, tests_run - tests_failed, tests_failed, errors);
		end
		done = (exp_ret.size() == 0) && (exp_st.size() == 0);
	end

endmodule

`default_nettype wire

// ==== sim/pipeline_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline_assertions (
	input logic       clk,
	input logic       rst,
	input logic       stall,
	input logic       branch_taken,
	input logic       retire_valid,
	input logic [4:0] retire_dst,
	input logic       store_valid
);

	// Load-use needs a load in EX, a branch needs a beq there
	a_stall_vs_branch: assert property (@(posedge clk) disable iff (rst)
		!(stall && branch_taken))
		else $error("stall and branch_taken high in the same cycle");

	a_no_r0_retire: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_dst != 5'd0)
		else $error("retire_valid raised for register 0");

	a_quiet_in_reset: assert property (@(posedge clk)
		rst |-> !retire_valid && !store_valid)
		else $error("retire or store activity during reset");

endmodule

bind pipeline pipeline_assertions u_assert (
	.clk(clk),
	.rst(rst),
	.stall(stall),
	.branch_taken(branch_taken),
	.retire_valid(retire_valid),
	.retire_dst(retire_dst),
	.store_valid(store_valid)
);

`default_nettype wire

// ==== sim/pipeline_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline_tb;

	import mips_pkg::*;

	localparam int PC_BITS = 7;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int MEM_WORDS = 1 << PC_BITS;
	localparam int PROG_LEN = 40; // Rest of imem is nops
	localparam int NUM_TESTS = 6;

	logic clk;
	logic rst;
	logic enable;
	logic imem_we;
	logic [PC_BITS-1:0] imem_addr;
	logic [31:0] imem_data;
	logic retire_valid;
	logic [4:0] retire_dst;
	logic [31:0] retire_data;
	logic store_valid;
	logic [PC_BITS-1:0] store_addr;
	logic [31:0] store_data;

	logic start;
	logic finish_test;
	logic report;
	logic [2:0] test_id;
	logic [7:0] prog_len;
	logic done;
	int errors;

	logic [31:0] prog [0:MEM_WORDS-1];
	logic [31:0] rng = 32'h6890;
	logic [MEM_WORDS-1:0] written = '0; // Data words known to hold a value

	pipeline #(.PC_BITS(PC_BITS)) uut (
		.clk(clk), .rst(rst), .enable(enable),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.retire_valid(retire_valid), .retire_dst(retire_dst), .retire_data(retire_data),
		.store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
	);

	pipeline_checker #(.PC_BITS(PC_BITS)) chk (
		.clk(clk), .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.retire_valid(retire_valid), .retire_dst(retire_dst), .retire_data(retire_data),
		.store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
		.start(start), .finish_test(finish_test), .report(report),
		.test_id(test_id), .prog_len(prog_len), .done(done), .errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog allows 8 cycles per imem word plus reset for every test
	initial begin
		#(CLK_PERIOD * NUM_TESTS * (MEM_WORDS * 8 + RESET_CYCLES));
		$display("Timeout: the tests did not finish in the time allowed");
		$display("Test failures found");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function int rnd(input int n);
		rng = xorshift(rng);
		return int'(rng % n);
	endfunction

	function automatic logic [31:0] make_r(input logic [5:0] fn, input int rd, rs, rt);
		instr_t w;
		w = '0;
		w.r.opcode = OP_RTYPE;
		w.r.rs = 5'(rs);
		w.r.rt = 5'(rt);
		w.r.rd = 5'(rd);
		w.r.funct = fn;
		return w;
	endfunction

	function automatic logic [31:0] make_i(input logic [5:0] op, input int rt, rs,
		input logic [15:0] imm);
		instr_t w;
		w.i.opcode = op;
		w.i.rs = 5'(rs);
		w.i.rt = 5'(rt);
		w.i.imm16 = imm;
		return w;
	endfunction

	function int pick_reg(input int kind);
		if (kind == 6 && rnd(3) == 0) begin
			return 0; // Lean on r0
		end
		return rnd(8);
	endfunction

	function logic [5:0] pick_fn();
		case (rnd(5))
			0: return FN_ADD;
			1: return FN_SUB;
			2: return FN_AND;
			3: return FN_OR;
			default: return FN_SLT;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Random program for one test kind
	task automatic build_program(input int kind);
		int shadow;
		int pend;
		int cls;
		int a;
		int r;
		int off;
		logic in_shadow;
		shadow = 0;
		pend = -1;
		for (int i = 0; i < MEM_WORDS; i++) begin
			in_shadow = shadow > 0; // May be skipped by a taken beq
			if (in_shadow) shadow--;
			cls = rnd(10);
			if (i >= PROG_LEN) begin
				prog[i] = 32'd0; // nop tail
			end else if (pend >= 0) begin
				prog[i] = make_r(pick_fn(), pick_reg(kind), pend, rnd(8)); // Load-use
				pend = -1;
			end else if ((kind == 3 || kind == 5) && cls < 4) begin
				a = rnd(MEM_WORDS);
				if (rnd(2) == 0 || written == '0) begin
					prog[i] = make_i(OP_SW, rnd(8), 0, 16'(a));
					if (!in_shadow) written[a] = 1'b1;
				end else begin
					while (!written[a]) a = (a + 1) % MEM_WORDS;
					r = pick_reg(kind);
					prog[i] = make_i(OP_LW, r, 0, 16'(a));
					if (rnd(2) == 0) pend = r;
				end
			end else if ((kind == 4 || kind == 5) && cls >= 8) begin
				off = rnd(3) + 1; // Forward only
				prog[i] = make_i(OP_BEQ, rnd(4), rnd(4), 16'(off));
				if (off > shadow) shadow = off;
			end else if (cls < 4) begin
				prog[i] = make_i(OP_ADDI, pick_reg(kind), pick_reg(kind), 16'(rnd(65536)));
			end else begin
				prog[i] = make_r(pick_fn(), pick_reg(kind), pick_reg(kind), pick_reg(kind));
			end
		end
	endtask

	task automatic load_program();
		for (int a = 0; a < MEM_WORDS; a++) begin
			@(posedge clk);
			#1;
			imem_we = 1'b1;
			imem_addr = PC_BITS'(a);
			imem_data = prog[a];
		end
		@(posedge clk);
		#1;
		imem_we = 1'b0;
	endtask

	task automatic run_test(input int id, input int len);
		rst = 1'b1;
		enable = 1'b0;
		@(posedge clk);
		#1;
		enable = 1'b1; // Pipeline clocked through reset
		repeat (RESET_CYCLES - 1) @(posedge clk);
		#1;
		rst = 1'b0;
		enable = 1'b0;
		if (id != 1) begin
			build_program(id);
			load_program();
		end
		@(posedge clk);
		#1;
		test_id = 3'(id);
		prog_len = 8'(len);
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		if (id == 1) begin
			repeat (20) @(posedge clk); // Idle with enable low
			#1;
		end else begin
			enable = 1'b1;
			while (!done) begin
				@(posedge clk);
				#1;
				if (id == 5) enable = (rnd(4) != 0); // Random freezes
			end
			enable = 1'b1;
			repeat (8) @(posedge clk); // Catch stray retires
			#1;
		end
		enable = 1'b0;
		finish_test = 1'b1;
		@(posedge clk);
		#1;
		finish_test = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		enable = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		start = 1'b0;
		finish_test = 1'b0;
		report = 1'b0;
		test_id = '0;
		prog_len = '0;
		run_test(1, 0);
		for (int t = 2; t <= NUM_TESTS; t++) begin
			run_test(t, PROG_LEN);
		end
		report = 1'b1;
		@(posedge clk);
		#1;
		report = 1'b0;
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/hazard_unit.sv
src/pipeline.sv
sim/pipeline_checker.sv
sim/pipeline_assertions.sv
sim/pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module pipeline_tb -o pipeline_sim
out=$(./obj_dir/pipeline_sim)
echo "$out"
echo "$out" | grep -qF "All tests passed!"
